// ==== Makefile ====
# Verilator simulation of the half-precision FMA unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fma_unit \
		-f fma_unit.f -Mdir obj_dir -o tb_fma_unit
	./obj_dir/tb_fma_unit | tee sim.log
	@grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== fma_unit.f ====
+incdir+rtl
rtl/fma_pkg.sv
rtl/fma_prep_if.sv
rtl/fma_classifier.sv
rtl/fma_operand_prep.sv
rtl/fma_mantissa_add.sv
rtl/fma_pipe_stage.sv
rtl/fma_normalize_round.sv
rtl/fma_unit.sv
testbench/tb_fma_unit.sv

// ==== rtl/fma_classifier.sv ====
// ---------------------------------------
// Classifies one half-precision operand
// Exactly one of the first five bits is set
// ---------------------------------------
`timescale 1ns/10ps
`include "fma_config.svh"

module fma_classifier (
  input  fma_pkg::fp_t      operand_i,
  output fma_pkg::fp_info_t info_o
);

  logic exp_zero;
  logic exp_ones;
  logic man_zero;

  // Field decode
  assign exp_zero = (operand_i.exponent == '0);
  assign exp_ones = (operand_i.exponent == '1);
  assign man_zero = (operand_i.mantissa == '0);

  assign info_o.is_zero       = exp_zero & man_zero;
  assign info_o.is_subnormal  = exp_zero & ~man_zero;
  assign info_o.is_normal     = ~exp_zero & ~exp_ones;
  assign info_o.is_inf        = exp_ones & man_zero;
  assign info_o.is_nan        = exp_ones & ~man_zero;
  // Quiet bit is the mantissa MSB
  assign info_o.is_signalling = exp_ones & ~man_zero &
                                ~operand_i.mantissa[`FMA_MAN_BITS-1];

endmodule

// ==== rtl/fma_config.svh ====
// ---------------------------------------
// Format and datapath widths of the FMA unit
// Fixed to IEEE half precision, bias 15
// Derived widths must be kept consistent
// with the format widths by hand
// ---------------------------------------
`ifndef FMA_CONFIG_SVH
`define FMA_CONFIG_SVH

// Half-precision format fields
`define FMA_EXP_BITS 5
`define FMA_MAN_BITS 10
`define FMA_WIDTH 16
`define FMA_BIAS 15

// Precision p, including the implicit bit
`define FMA_PREC_BITS 11
// Internal sum of 3p+4 bits
`define FMA_SUM_WIDTH 37
// Signed internal exponent, two bits above the format
`define FMA_EXP_WIDTH 7
// Shift amounts up to 3p+4
`define FMA_SHAMT_WIDTH 6
// Lower 2p+3 sum bits seen by the leading-zero count
`define FMA_LOWER_SUM_WIDTH 25

`endif

// ==== rtl/fma_mantissa_add.sv ====
// ---------------------------------------
// Product, addend alignment and 3p+4 adder
// Sum is returned as a magnitude
// ---------------------------------------
`timescale 1ns/10ps
`include "fma_config.svh"

module fma_mantissa_add (
  fma_prep_if.add                   prep_i,
  output logic [`FMA_SUM_WIDTH-1:0] sum_o,
  output logic                      sticky_o,
  output logic                      final_sign_o
);

  localparam int PREC = `FMA_PREC_BITS;
  localparam int SW   = `FMA_SUM_WIDTH;

  logic [2*PREC-1:0] product;
  logic [SW-1:0]     product_shifted;
  logic [SW-1:0]     addend_after_shift;
  logic [PREC-1:0]   addend_sticky_bits;
  logic [SW-1:0]     addend_shifted;
  logic              carry_in;
  logic [SW:0]       sum_raw;
  logic [SW:0]       sum_neg;
  logic              sum_carry;

  // p x p multiplier
  assign product = prep_i.mantissa_a * prep_i.mantissa_b;
  // Layout | p+2 zeros | product | round, sticky |
  assign product_shifted = SW'({product, 2'b00});

  // Addend starts above the sum, up to p bits fall out as sticky
  assign {addend_after_shift, addend_sticky_bits} =
      {prep_i.mantissa_c, {SW{1'b0}}} >> prep_i.addend_shamt;
  assign sticky_o = |addend_sticky_bits;

  // One's complement, plus one unless sticky bits were lost
  assign addend_shifted = prep_i.eff_sub ? ~addend_after_shift : addend_after_shift;
  assign carry_in       = prep_i.eff_sub & ~sticky_o;

  // ---------------------------------------
  // Adder and sign fix-up
  // ---------------------------------------
  assign sum_raw   = product_shifted + addend_shifted + carry_in;
  assign sum_carry = sum_raw[SW];
  assign sum_neg   = -sum_raw;

  // No carry on a subtraction means a negative sum
  assign sum_o = (prep_i.eff_sub && !sum_carry) ? sum_neg[SW-1:0] : sum_raw[SW-1:0];

  assign final_sign_o = prep_i.eff_sub ? (sum_carry == prep_i.tent_sign) : prep_i.tent_sign;

endmodule

// ==== rtl/fma_normalize_round.sv ====
// ---------------------------------------
// Normalization, rounding and flags
// RNE and RTZ only
// UF means zero exponent field after
// rounding together with an inexact result
// ---------------------------------------
`timescale 1ns/10ps
`include "fma_config.svh"

module fma_normalize_round (
  input  fma_pkg::mid_payload_t mid_i,
  output fma_pkg::out_payload_t out_o
);

  localparam int PREC = `FMA_PREC_BITS;
  localparam int SW   = `FMA_SUM_WIDTH;
  localparam int LW   = `FMA_LOWER_SUM_WIDTH;
  localparam int LZW  = $clog2(LW);
  localparam int EB   = `FMA_EXP_BITS;
  localparam int MB   = `FMA_MAN_BITS;
  localparam int EW   = `FMA_EXP_WIDTH;
  localparam int SHW  = `FMA_SHAMT_WIDTH;

  logic signed [EW-1:0] exp_product, exp_diff, tent_exp;
  logic [LZW-1:0]       lz_count;
  logic                 lz_empty;
  logic [SHW-1:0]       norm_shamt;
  logic signed [EW-1:0] norm_exp, final_exp;
  logic [SW:0]          sum_shifted;
  logic [PREC:0]        final_man;
  logic [LW-1:0]        sum_sticky_bits;
  logic                 sticky_after;
  logic                 of_before, of_after, round_up, exact_zero, inexact;
  logic [EB-1:0]        pre_exp;
  logic [MB-1:0]        pre_man;
  logic [EB+MB-1:0]     pre_abs, rounded_abs;
  logic [1:0]           round_sticky;
  logic                 rounded_sign;
  fma_pkg::status_t     regular_status;

  // Signed views of the exponent fields
  assign exp_product = mid_i.exp_product;
  assign exp_diff    = mid_i.exp_diff;
  assign tent_exp    = mid_i.tent_exp;

  // ---------------------------------------
  // Leading zeros in the lower 2p+3 bits
  // ---------------------------------------
  always_comb begin : lzc
    lz_count = '0;
    lz_empty = 1'b1;
    for (int i = LW - 1; i >= 0; i--) begin
      if (lz_empty && mid_i.sum[i]) begin
        lz_empty = 1'b0;
        lz_count = LZW'(LW - 1 - i);
      end
    end
  end

  always_comb begin : norm_shift
    if ((exp_diff <= 0) || (mid_i.eff_sub && (exp_diff <= 2))) begin
      // Product anchored or cancellation
      if ((int'(exp_product) - int'(lz_count) + 1 >= 0) && !lz_empty) begin
        norm_shamt = SHW'(PREC + 2 + lz_count);
        norm_exp   = EW'(int'(exp_product) - int'(lz_count) + 1);
      end else begin
        // Capped at the subnormal boundary
        norm_shamt = SHW'(PREC + 2 + exp_product);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment
      norm_shamt = mid_i.addend_shamt;
      norm_exp   = tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // Leading one may still sit one bit off
  always_comb begin : small_norm
    {final_man, sum_sticky_bits} = sum_shifted[SW-1:0];
    final_exp                    = norm_exp;
    if (sum_shifted[SW]) begin
      {final_man, sum_sticky_bits} = sum_shifted[SW:1];
      final_exp                    = EW'(norm_exp + 1);
    end else if (!sum_shifted[SW-1]) begin
      if (norm_exp > 1) begin
        {final_man, sum_sticky_bits} = {sum_shifted[SW-2:0], 1'b0};
        final_exp                    = EW'(norm_exp - 1);
      end else begin
        final_exp = '0;
      end
    end
  end

  assign sticky_after = (|sum_sticky_bits) | mid_i.sticky;

  // ---------------------------------------
  // Rounding
  // ---------------------------------------
  // Overflow saturates to max normal with round and sticky set
  assign of_before    = (final_exp >= (2**EB - 1));
  assign pre_exp      = of_before ? EB'(2**EB - 2) : final_exp[EB-1:0];
  assign pre_man      = of_before ? '1 : final_man[MB:1];
  assign pre_abs      = {pre_exp, pre_man};
  assign round_sticky = of_before ? 2'b11 : {final_man[0], sticky_after};

  // Ties go to even, RTZ just truncates
  assign round_up = (mid_i.rnd_mode == fma_pkg::RNE) && round_sticky[1] &&
                    (round_sticky[0] || pre_abs[0]);
  assign rounded_abs = pre_abs + round_up;

  // Exact cancellation gives +0
  assign exact_zero   = (pre_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && mid_i.eff_sub) ? 1'b0 : mid_i.final_sign;

  assign of_after = &rounded_abs[EB+MB-1:MB];
  assign inexact  = (|round_sticky) | of_before | of_after;

  always_comb begin : result_select
    regular_status    = '0;
    regular_status.of = of_before | of_after;
    regular_status.uf = (rounded_abs[EB+MB-1:MB] == '0) & inexact;
    regular_status.nx = inexact;
    // Bypassed special cases win
    if (mid_i.is_special) begin
      out_o.result = mid_i.special_result;
      out_o.status = mid_i.special_status;
    end else begin
      out_o.result = {rounded_sign, rounded_abs};
      out_o.status = regular_status;
    end
  end

endmodule

// ==== rtl/fma_operand_prep.sv ====
// ---------------------------------------
// Operation select, special cases and the
// exponent path of the FMA
// Only RNE and RTZ exist, so MUL adds -0
// Special results are canonical qNaN or inf
// ---------------------------------------
`timescale 1ns/10ps
`include "fma_config.svh"

module fma_operand_prep (
  input  fma_pkg::fp_t                      operand_a_i,
  input  fma_pkg::fp_t                      operand_b_i,
  input  fma_pkg::fp_t                      operand_c_i,
  input  fma_pkg::fp_info_t                 info_a_i,
  input  fma_pkg::fp_info_t                 info_b_i,
  input  fma_pkg::fp_info_t                 info_c_i,
  input  fma_pkg::op_e                      op_i,
  input  logic                              op_mod_i,
  input  fma_pkg::round_mode_e              rnd_mode_i,
  fma_prep_if.prep                          prep_o,
  output logic signed [`FMA_EXP_WIDTH-1:0]  exp_product_o,
  output logic signed [`FMA_EXP_WIDTH-1:0]  exp_diff_o,
  output logic signed [`FMA_EXP_WIDTH-1:0]  tent_exp_o,
  output logic                              is_special_o,
  output fma_pkg::fp_t                      special_result_o,
  output fma_pkg::status_t                  special_status_o
);

  localparam int PREC = `FMA_PREC_BITS;
  localparam int EW   = `FMA_EXP_WIDTH;
  localparam int SHW  = `FMA_SHAMT_WIDTH;

  fma_pkg::fp_t         operand_a, operand_b, operand_c;
  fma_pkg::fp_info_t    info_a, info_b, info_c;
  logic                 any_inf, any_nan, any_snan;
  logic                 prod_inf, eff_sub;
  logic signed [EW-1:0] exp_a, exp_b, exp_c, exp_addend;

  // ---------------------------------------
  // Operand adjustment
  // ---------------------------------------
  always_comb begin : op_select
    operand_a = operand_a_i;
    operand_b = operand_b_i;
    operand_c = operand_c_i;
    info_a    = info_a_i;
    info_b    = info_b_i;
    info_c    = info_c_i;
    // Modifier negates the addend
    operand_c.sign = operand_c_i.sign ^ op_mod_i;
    unique case (op_i)
      fma_pkg::FMADD: ;
      // Negated product
      fma_pkg::FNMSUB: operand_a.sign = ~operand_a_i.sign;
      // Multiplicand becomes +1.0
      fma_pkg::ADD: begin
        operand_a = '{sign: 1'b0, exponent: `FMA_EXP_BITS'(`FMA_BIAS), mantissa: '0};
        info_a    = '{is_normal: 1'b1, default: 1'b0};
      end
      // Exact zero sums round to +0 in both modes, so -0 keeps the product sign
      fma_pkg::MUL: begin
        operand_c = '{sign: rnd_mode_i inside {fma_pkg::RNE, fma_pkg::RTZ},
                      exponent: '0, mantissa: '0};
        info_c    = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign any_inf  = info_a.is_inf | info_b.is_inf | info_c.is_inf;
  assign any_nan  = info_a.is_nan | info_b.is_nan | info_c.is_nan;
  assign any_snan = info_a.is_signalling | info_b.is_signalling | info_c.is_signalling;
  assign prod_inf = info_a.is_inf | info_b.is_inf;
  assign eff_sub  = operand_a.sign ^ operand_b.sign ^ operand_c.sign;

  // ---------------------------------------
  // Special cases, in priority order
  // ---------------------------------------
  always_comb begin : special_cases
    // Canonical quiet NaN by default
    special_result_o = '{sign: 1'b0, exponent: '1,
                         mantissa: {1'b1, {(`FMA_MAN_BITS-1){1'b0}}}};
    special_status_o = '0;
    is_special_o     = 1'b0;
    if ((info_a.is_inf && info_b.is_zero) || (info_a.is_zero && info_b.is_inf)) begin
      // inf*0 is invalid even with a quiet NaN addend
      is_special_o        = 1'b1;
      special_status_o.nv = 1'b1;
    end else if (any_nan) begin
      is_special_o        = 1'b1;
      special_status_o.nv = any_snan;
    end else if (any_inf) begin
      is_special_o = 1'b1;
      if (prod_inf && info_c.is_inf && eff_sub) begin
        // Opposite infinities cancel
        special_status_o.nv = 1'b1;
      end else if (prod_inf) begin
        special_result_o = '{sign: operand_a.sign ^ operand_b.sign, exponent: '1,
                             mantissa: '0};
      end else begin
        special_result_o = '{sign: operand_c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

  // ---------------------------------------
  // Exponent path, exponents stay biased
  // ---------------------------------------
  assign exp_a = {2'b00, operand_a.exponent};
  assign exp_b = {2'b00, operand_b.exponent};
  assign exp_c = {2'b00, operand_c.exponent};

  // Subnormals and zero sit at exponent 1
  assign exp_addend = exp_c + EW'(!info_c.is_normal);
  // Zero product gets the smallest exponent
  assign exp_product_o = (info_a.is_zero || info_b.is_zero) ? EW'(2 - `FMA_BIAS) :
                         EW'(exp_a + info_a.is_subnormal + exp_b + info_b.is_subnormal
                             - `FMA_BIAS);
  assign exp_diff_o = exp_addend - exp_product_o;
  assign tent_exp_o = (exp_diff_o > 0) ? exp_addend : exp_product_o;

  always_comb begin : addend_shift
    if (exp_diff_o <= -(2 * PREC + 1)) begin
      // Addend lands in the sticky bit only
      prep_o.addend_shamt = SHW'(3 * PREC + 4);
    end else if (exp_diff_o <= PREC + 2) begin
      prep_o.addend_shamt = SHW'(PREC + 3 - exp_diff_o);
    end else begin
      // Addend anchored, product only sticky
      prep_o.addend_shamt = '0;
    end
  end

  // Implicit bit from the class
  assign prep_o.mantissa_a = {info_a.is_normal, operand_a.mantissa};
  assign prep_o.mantissa_b = {info_b.is_normal, operand_b.mantissa};
  assign prep_o.mantissa_c = {info_c.is_normal, operand_c.mantissa};
  assign prep_o.eff_sub    = eff_sub;
  assign prep_o.tent_sign  = operand_a.sign ^ operand_b.sign;

endmodule

// ==== rtl/fma_pipe_stage.sv ====
// ---------------------------------------
// One valid/ready register stage
// Accepts while empty or draining, so a
// full pipeline moves one item per cycle
// ---------------------------------------
`timescale 1ns/10ps

module fma_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Ready when downstream takes the item or the stage is empty
  assign ready_o = ready_i | ~valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only loads on an accepted item
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== rtl/fma_pkg.sv ====
// ---------------------------------------
// Types shared by the FMA datapath
// Status flag order follows RISC-V fflags
// ---------------------------------------
`include "fma_config.svh"

package fma_pkg;

  // Half-precision float
  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exponent;
    logic [`FMA_MAN_BITS-1:0] mantissa;
  } fp_t;

  // Operand class
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // Exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // Operation code, the modifier bit negates the addend
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } op_e;

  typedef enum logic {
    RNE,
    RTZ
  } round_mode_e;

  // ---------------------------------------
  // Pipeline payloads
  // ---------------------------------------
  // Adder stage results for normalization
  typedef struct packed {
    logic                               eff_sub;
    logic signed [`FMA_EXP_WIDTH-1:0]   exp_product;
    logic signed [`FMA_EXP_WIDTH-1:0]   exp_diff;
    logic signed [`FMA_EXP_WIDTH-1:0]   tent_exp;
    logic        [`FMA_SHAMT_WIDTH-1:0] addend_shamt;
    logic                               sticky;
    logic        [`FMA_SUM_WIDTH-1:0]   sum;
    logic                               final_sign;
    round_mode_e                        rnd_mode;
    logic                               is_special;
    fp_t                                special_result;
    status_t                            special_status;
  } mid_payload_t;

  // Final result
  typedef struct packed {
    fp_t     result;
    status_t status;
  } out_payload_t;

endpackage

// ==== rtl/fma_prep_if.sv ====
// ---------------------------------------
// Operand preparation to mantissa adder
// Purely combinational, no handshake
// ---------------------------------------
`timescale 1ns/10ps
`include "fma_config.svh"

interface fma_prep_if;

  // Mantissas with implicit bit in front
  logic [`FMA_PREC_BITS-1:0]   mantissa_a;
  logic [`FMA_PREC_BITS-1:0]   mantissa_b;
  logic [`FMA_PREC_BITS-1:0]   mantissa_c;
  // Product and addend signs differ
  logic                        eff_sub;
  // Sign of the product, fixed up after the add
  logic                        tent_sign;
  // Right shift of the addend against the product
  logic [`FMA_SHAMT_WIDTH-1:0] addend_shamt;

  modport prep (
    output mantissa_a, mantissa_b, mantissa_c, eff_sub, tent_sign, addend_shamt
  );

  modport add (
    input mantissa_a, mantissa_b, mantissa_c, eff_sub, tent_sign, addend_shamt
  );

endinterface

// ==== rtl/fma_unit.sv ====
// ---------------------------------------
// Half-precision fused multiply-add
// FMADD, FNMSUB, ADD, MUL, the modifier
// negates the addend, RNE or RTZ
// Two register stages, latency 2 cycles
// ---------------------------------------
`timescale 1ns/10ps
`include "fma_config.svh"

module fma_unit (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [`FMA_WIDTH-1:0] operand_a_i,
  input  logic [`FMA_WIDTH-1:0] operand_b_i,
  input  logic [`FMA_WIDTH-1:0] operand_c_i,
  input  logic [1:0]            op_i,
  input  logic                  op_mod_i,
  input  logic                  rnd_mode_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output logic [`FMA_WIDTH-1:0] result_o,
  output logic [4:0]            status_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);

  fma_pkg::fp_info_t     info_a, info_b, info_c;
  fma_pkg::mid_payload_t mid_d, mid_q;
  fma_pkg::out_payload_t out_d, out_q;
  logic                  mid_valid;
  logic                  mid_ready;

  fma_prep_if prep_if ();

  // ---------------------------------------
  // Classification and preparation
  // ---------------------------------------
  fma_classifier i_class_a (.operand_i(operand_a_i), .info_o(info_a));
  fma_classifier i_class_b (.operand_i(operand_b_i), .info_o(info_b));
  fma_classifier i_class_c (.operand_i(operand_c_i), .info_o(info_c));

  fma_operand_prep i_operand_prep (
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .operand_c_i      (operand_c_i),
    .info_a_i         (info_a),
    .info_b_i         (info_b),
    .info_c_i         (info_c),
    .op_i             (fma_pkg::op_e'(op_i)),
    .op_mod_i         (op_mod_i),
    .rnd_mode_i       (fma_pkg::round_mode_e'(rnd_mode_i)),
    .prep_o           (prep_if),
    .exp_product_o    (mid_d.exp_product),
    .exp_diff_o       (mid_d.exp_diff),
    .tent_exp_o       (mid_d.tent_exp),
    .is_special_o     (mid_d.is_special),
    .special_result_o (mid_d.special_result),
    .special_status_o (mid_d.special_status)
  );

  fma_mantissa_add i_mantissa_add (
    .prep_i       (prep_if),
    .sum_o        (mid_d.sum),
    .sticky_o     (mid_d.sticky),
    .final_sign_o (mid_d.final_sign)
  );

  // Remaining mid payload fields
  assign mid_d.eff_sub      = prep_if.eff_sub;
  assign mid_d.addend_shamt = prep_if.addend_shamt;
  assign mid_d.rnd_mode     = fma_pkg::round_mode_e'(rnd_mode_i);

  // ---------------------------------------
  // Pipeline
  // ---------------------------------------
  fma_pipe_stage #(.payload_t(fma_pkg::mid_payload_t)) i_mid_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (in_valid_i),
    .ready_o  (in_ready_o),
    .data_i   (mid_d),
    .valid_o  (mid_valid),
    .ready_i  (mid_ready),
    .data_o   (mid_q)
  );

  fma_normalize_round i_normalize_round (.mid_i(mid_q), .out_o(out_d));

  fma_pipe_stage #(.payload_t(fma_pkg::out_payload_t)) i_out_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (mid_valid),
    .ready_o  (mid_ready),
    .data_i   (out_d),
    .valid_o  (out_valid_o),
    .ready_i  (out_ready_i),
    .data_o   (out_q)
  );

  assign result_o = out_q.result;
  assign status_o = out_q.status;

endmodule

// ==== testbench/tb_fma_unit.sv ====
// ---------------------------------------
// Testbench for the half-precision FMA
// Expected values come from exact integer
// a*b+c, rounded to 11 significant bits
// Operands are small integers, so only the
// directed cases round or overflow
// ---------------------------------------
`timescale 1ns/10ps

module tb_fma_unit;

  logic        clk_i;
  logic        arst_n_i;
  logic [15:0] operand_a_i, operand_b_i, operand_c_i;
  logic [1:0]  op_i;
  logic        op_mod_i, rnd_mode_i;
  logic        in_valid_i, in_ready_o;
  logic [15:0] result_o;
  logic [4:0]  status_o;
  logic        out_valid_o, out_ready_i;

  // LFSR state, seed reduced to 16 bits
  logic [15:0] lfsr_state = 16'(85152);
  logic        ready_random = 1'b0;
  int          value_errors = 0;
  int          other_errors = 0;

  // Expected {result, status} per accepted input, in order
  logic [20:0] exp_fifo[$];
  logic [20:0] pending_exp = '0;
  logic [15:0] exp_result = '0;
  logic [4:0]  exp_status = '0;
  int          exp_count = 0;
  int          after_reset = 0;

  // Handshake view taken at the falling edge
  logic        in_fire_s = 1'b0;
  logic        out_fire_s = 1'b0;
  logic        ready_s = 1'b0;
  logic        hold_s = 1'b0;
  logic [15:0] result_s = '0;
  logic [4:0]  status_s = '0;

  logic        held_valid = 1'b0;
  logic [15:0] held_result = '0;
  logic [4:0]  held_status = '0;
  logic        fire_prev = 1'b0;
  logic        lat_check = 1'b0;

  fma_unit i_dut (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // ---------------------------------------
  // Stimulus helpers
  // ---------------------------------------
  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  // Integer to half precision as {result, status}, RNE or RTZ
  function automatic logic [20:0] int_to_half(input logic sign, input int mag, input logic rtz);
    int   msb;
    int   shift;
    int   keep;
    int   rem;
    int   half;
    logic inexact;
    logic up;
    if (mag == 0) begin
      return {sign, 15'h0, 5'h0};
    end
    msb = 0;
    for (int i = 0; i < 31; i++) begin
      if ((mag >> i) != 0) begin
        msb = i;
      end
    end
    shift   = (msb > 10) ? msb - 10 : 0;
    keep    = (msb > 10) ? mag >> shift : mag << (10 - msb);
    rem     = mag & ((1 << shift) - 1);
    half    = (shift > 0) ? (1 << (shift - 1)) : 0;
    inexact = (rem != 0);
    // Ties to even on the kept LSB
    up      = !rtz && (shift > 0) && ((rem > half) || ((rem == half) && keep[0]));
    keep    = keep + int'(up);
    if (keep == 2048) begin
      keep = 1024;
      msb++;
    end
    // Overflow gives inf, or max normal when truncating
    if (msb + 15 >= 31) begin
      return {sign, rtz ? 15'h7BFF : 15'h7C00, 5'b00101};
    end
    return {sign, 5'(msb + 15), 10'(keep), 4'b0000, inexact};
  endfunction

  function automatic logic [15:0] half_of(input logic sign, input int mag);
    logic [20:0] enc;
    enc = int_to_half(sign, mag, 1'b0);
    return enc[20:5];
  endfunction

  // Reference result of one operation on integer operands
  function automatic logic [20:0] expected_fma(
    input logic sa, input int ma, input logic sb, input int mb, input logic sc,
    input int mc, input logic [1:0] op, input logic op_mod, input logic rtz);
    logic sp;
    int   mp;
    int   value;
    sc = sc ^ op_mod;
    if (op == fma_pkg::FNMSUB) begin
      sa = ~sa;
    end else if (op == fma_pkg::ADD) begin
      sa = 1'b0;
      ma = 1;
    end else if (op == fma_pkg::MUL) begin
      // Addend is -0 whatever the modifier
      sc = 1'b1;
      mc = 0;
    end
    sp    = sa ^ sb;
    mp    = ma * mb;
    value = (sp ? -mp : mp) + (sc ? -mc : mc);
    if (value != 0) begin
      return int_to_half(value < 0, (value < 0) ? -value : value, rtz);
    end else if ((mp == 0) && (mc == 0) && (sp == sc)) begin
      // Two zeros of equal sign keep it
      return {sp, 20'h0};
    end
    return 21'h0;
  endfunction

  // One clock, drive 10 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
    out_ready_i = ready_random ? lfsr_bit() : 1'b1;
  endtask

  task automatic issue(input logic [15:0] a, input logic [15:0] b, input logic [15:0] c,
                       input logic [1:0] op, input logic op_mod, input logic rnd,
                       input logic [20:0] expected);
    int   waited;
    logic accepted;
    waited      = 0;
    accepted    = 1'b0;
    operand_a_i = a;
    operand_b_i = b;
    operand_c_i = c;
    op_i        = op;
    op_mod_i    = op_mod;
    rnd_mode_i  = rnd;
    pending_exp = expected;
    in_valid_i  = 1'b1;
    while (!accepted && (waited < 50)) begin
      @(negedge clk_i);
      accepted = in_ready_o;
      next_cycle();
      waited++;
    end
    in_valid_i = 1'b0;
    if (!accepted) begin
      other_errors++;
      $display("Input handshake timed out at %0t", $time);
    end
  endtask

  task automatic random_op();
    logic       sa, sb, sc, op_mod, rnd;
    int         ma, mb, mc;
    logic [1:0] op;
    sa     = lfsr_bit();
    ma     = rand_bits(6) % 41;
    sb     = lfsr_bit();
    mb     = rand_bits(6) % 41;
    sc     = lfsr_bit();
    mc     = rand_bits(6) % 41;
    op     = 2'(rand_bits(2));
    op_mod = lfsr_bit();
    rnd    = lfsr_bit();
    issue(half_of(sa, ma), half_of(sb, mb), half_of(sc, mc), op, op_mod, rnd,
          expected_fma(sa, ma, sb, mb, sc, mc, op, op_mod, rnd));
  endtask

  task automatic directed_ops();
    // Rounding and overflow through ADD, which ignores a
    issue(16'h0, half_of(0, 2047), half_of(0, 2), fma_pkg::ADD, 0, 0, {16'h6800, 5'b00001});
    issue(16'h0, half_of(0, 2047), half_of(0, 2), fma_pkg::ADD, 0, 1, {16'h6800, 5'b00001});
    issue(16'h0, half_of(0, 2048), half_of(0, 3), fma_pkg::ADD, 0, 0, {16'h6802, 5'b00001});
    issue(16'h0, half_of(0, 2048), half_of(0, 3), fma_pkg::ADD, 0, 1, {16'h6801, 5'b00001});
    issue(16'h0, half_of(0, 60000), half_of(0, 60000), fma_pkg::ADD, 0, 0,
          {16'h7C00, 5'b00101});
    issue(16'h0, half_of(0, 60000), half_of(0, 60000), fma_pkg::ADD, 0, 1,
          {16'h7BFF, 5'b00101});
    // NaN, inf*0, inf-inf and an infinite product
    issue(16'h7E00, 16'h4000, 16'h4500, fma_pkg::FMADD, 0, 0, {16'h7E00, 5'b00000});
    issue(16'h4000, 16'h7D00, 16'h4500, fma_pkg::FMADD, 0, 0, {16'h7E00, 5'b10000});
    issue(16'h7C00, 16'h0000, 16'h7E00, fma_pkg::FMADD, 0, 0, {16'h7E00, 5'b10000});
    issue(16'h7C00, 16'h3C00, 16'hFC00, fma_pkg::FMADD, 0, 0, {16'h7E00, 5'b10000});
    issue(16'hFC00, 16'h4000, 16'h4500, fma_pkg::FMADD, 0, 0, {16'hFC00, 5'b00000});
  endtask

  // ---------------------------------------
  // Scoreboard
  // ---------------------------------------
  always @(negedge clk_i) begin : sample_handshakes
    in_fire_s  = in_valid_i && in_ready_o;
    out_fire_s = out_valid_o && out_ready_i;
    ready_s    = out_ready_i;
    hold_s     = out_valid_o && !out_ready_i;
    result_s   = result_o;
    status_s   = status_o;
  end

  always @(posedge clk_i) begin : track_expected
    if (!arst_n_i) begin
      exp_fifo.delete();
      after_reset = 0;
      fire_prev   = 1'b0;
      lat_check   = 1'b0;
      held_valid  = 1'b0;
    end else begin
      if (after_reset < 2) begin
        after_reset++;
      end
      // Input accepted one edge ago and output ready now
      lat_check   = fire_prev && ready_s;
      fire_prev   = in_fire_s;
      held_valid  = hold_s;
      held_result = result_s;
      held_status = status_s;
      if (out_fire_s && (exp_fifo.size() > 0)) begin
        void'(exp_fifo.pop_front());
      end
      if (in_fire_s) begin
        exp_fifo.push_back(pending_exp);
      end
    end
    exp_count = exp_fifo.size();
    if (exp_count > 0) begin
      exp_result = exp_fifo[0][20:5];
      exp_status = exp_fifo[0][4:0];
    end
  end

  // ---------------------------------------
  // Checks on the stable half of the cycle
  // ---------------------------------------
  reset_valid_chk: assert property (@(negedge clk_i) (after_reset < 2) |-> !out_valid_o)
    else begin
      value_errors++;
      $display("FAILED %0t out_valid_o expected 0 actual %b", $time, out_valid_o);
    end

  reset_ready_chk: assert property (@(negedge clk_i) (after_reset < 2) |-> in_ready_o)
    else begin
      value_errors++;
      $display("FAILED %0t in_ready_o expected 1 actual %b", $time, in_ready_o);
    end

  result_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
      (out_valid_o && out_ready_i && (exp_count > 0)) |-> (result_o == exp_result))
    else begin
      value_errors++;
      $display("FAILED %0t result_o expected %h actual %h", $time, exp_result, result_o);
    end

  status_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
      (out_valid_o && out_ready_i && (exp_count > 0)) |-> (status_o == exp_status))
    else begin
      value_errors++;
      $display("FAILED %0t status_o expected %b actual %b", $time, exp_status, status_o);
    end

  // An output with nothing pending is a duplicate or spurious item
  spurious_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
      out_valid_o |-> (exp_count > 0))
    else begin
      other_errors++;
      $display("Output valid at %0t with no input pending", $time);
    end

  hold_result_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
      held_valid |-> (result_o == held_result))
    else begin
      value_errors++;
      $display("FAILED %0t result_o expected %h actual %h", $time, held_result, result_o);
    end

  hold_status_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
      held_valid |-> (status_o == held_status))
    else begin
      value_errors++;
      $display("FAILED %0t status_o expected %b actual %b", $time, held_status, status_o);
    end

  latency_chk: assert property (@(negedge clk_i) disable iff (!arst_n_i)
      lat_check |-> out_valid_o)
    else begin
      value_errors++;
      $display("FAILED %0t out_valid_o expected 1 actual %b", $time, out_valid_o);
    end

  // ---------------------------------------
  // Test sequence
  // ---------------------------------------
  initial begin : run_tests
    int waited;
    arst_n_i    = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i        = '0;
    op_mod_i    = 1'b0;
    rnd_mode_i  = 1'b0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    #10;
    arst_n_i = 1'b1;
    repeat (2) next_cycle();

    // Back to back with the output always ready
    for (int i = 0; i < 120; i++) begin
      random_op();
    end
    directed_ops();

    // Random back-pressure and input gaps
    ready_random = 1'b1;
    for (int i = 0; i < 250; i++) begin
      random_op();
      if (lfsr_bit()) begin
        next_cycle();
      end
    end

    ready_random = 1'b0;
    waited       = 0;
    while ((exp_count > 0) && (waited < 20)) begin
      next_cycle();
      waited++;
    end
    if (exp_count > 0) begin
      other_errors++;
      $display("Timed out draining %0d pending results", exp_count);
    end
    repeat (2) next_cycle();

    $display("Errors: %0d value, %0d other", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
